//--- hdl/pad_ctrl_macros.svh
/* Pad count and configuration field widths for the pad-control block.
   Included by the package and by every module that sizes ports with them. */

`ifndef PAD_CTRL_MACROS_SVH
`define PAD_CTRL_MACROS_SVH

// Number of pads, also the width of each peripheral group vector
`define N_IO 16

// Mux selection width, one code per group plus off
`define NBIT_PADMUX 2

// Electrical configuration word per pad
`define NBIT_PADCFG 6

`endif

//--- hdl/pad_ctrl_pkg.sv
/* Shared types for the pad-control block: pad index, mux selection and
   per-pad configuration word. */

`include "pad_ctrl_macros.svh"

package pad_ctrl_pkg;

  // Pad index, wide enough to address every pad
  typedef logic [$clog2(`N_IO)-1:0] pad_idx_t;

  // Peripheral group that owns a pad
  typedef enum logic [`NBIT_PADMUX-1:0] {
    PADMUX_PERIO  = 2'd0,
    PADMUX_APBIO  = 2'd1,
    PADMUX_FPGAIO = 2'd2,
    // Pad released, no group drives or sees it
    PADMUX_OFF    = 2'd3
  } padmux_sel_t;

  // Electrical pad configuration, driven straight to the pad frame
  typedef logic [`NBIT_PADCFG-1:0] padcfg_t;

  // Configuration word held by every pad after reset
  localparam padcfg_t PADCFG_RESET = '0;

endpackage

//--- hdl/pad_cfg_bank.sv
/* Bank of per-pad configuration registers, one entry per pad, written by a
   single-cycle strobe. The entry type is a parameter so one bank serves both fields. */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_cfg_bank #(
  parameter type    entry_t   = logic,
  parameter entry_t RESET_VAL = '0
) (
  input  logic                    ref_clk_i,
  input  logic                    rst_n_i,
  input  logic                    we_i,
  input  pad_ctrl_pkg::pad_idx_t  idx_i,
  input  entry_t                  data_i,
  output entry_t [`N_IO-1:0]      entries_o
);

  entry_t [`N_IO-1:0] entries_q;
  logic   [`N_IO-1:0] wr_en;

  // Decode the strobe onto the addressed entry
  always_comb begin
    wr_en        = '0;
    wr_en[idx_i] = we_i;
  end

  // One register per pad
  for (genvar i = 0; i < `N_IO; i++) begin : g_entry
    always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        entries_q[i] <= RESET_VAL;
      end else if (wr_en[i]) begin
        entries_q[i] <= data_i;
      end
    end
  end

  // Outputs come straight from the flops, so the new value is
  // visible right after the write edge
  assign entries_o = entries_q;

endmodule

//--- hdl/pad_mux_cell.sv
/* One pad's routing cell: picks the owning group's output and enable, and
   synchronizes the pad input before steering it to that group only. */

`timescale 1ns/1ps

module pad_mux_cell (
  input  logic                       ref_clk_i,
  input  logic                       rst_n_i,
  input  pad_ctrl_pkg::padmux_sel_t  sel_i,

  // Group outputs and enables for this pad
  input  logic                       perio_out_i,
  input  logic                       perio_oe_i,
  input  logic                       apbio_out_i,
  input  logic                       apbio_oe_i,
  input  logic                       fpgaio_out_i,
  input  logic                       fpgaio_oe_i,

  // Pad side
  input  logic                       pad_in_i,
  output logic                       pad_out_o,
  output logic                       pad_oe_o,

  // Steered input, one bit per group
  output logic                       perio_in_o,
  output logic                       apbio_in_o,
  output logic                       fpgaio_in_o
);

  import pad_ctrl_pkg::*;

  logic sel_perio;
  logic sel_apbio;
  logic sel_fpgaio;

  logic sync_meta_q;
  logic sync_q;

  // One-hot group decode, PADMUX_OFF matches none of them
  assign sel_perio  = (sel_i == PADMUX_PERIO);
  assign sel_apbio  = (sel_i == PADMUX_APBIO);
  assign sel_fpgaio = (sel_i == PADMUX_FPGAIO);

  // Output path
  always_comb begin
    pad_out_o = 1'b0;
    pad_oe_o  = 1'b0;
    case (sel_i)
      PADMUX_PERIO: begin
        pad_out_o = perio_out_i;
        pad_oe_o  = perio_oe_i;
      end
      PADMUX_APBIO: begin
        pad_out_o = apbio_out_i;
        pad_oe_o  = apbio_oe_i;
      end
      PADMUX_FPGAIO: begin
        pad_out_o = fpgaio_out_i;
        pad_oe_o  = fpgaio_oe_i;
      end
      // Released pad stays undriven
      default: begin
        pad_out_o = 1'b0;
        pad_oe_o  = 1'b0;
      end
    endcase
  end

  // Two-flop synchronizer on the pad input
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_meta_q <= 1'b0;
      sync_q      <= 1'b0;
    end else begin
      sync_meta_q <= pad_in_i;
      sync_q      <= sync_meta_q;
    end
  end

  // Steering follows the selection at once; only the owner sees the pad
  assign perio_in_o  = sel_perio  & sync_q;
  assign apbio_in_o  = sel_apbio  & sync_q;
  assign fpgaio_in_o = sel_fpgaio & sync_q;

endmodule

//--- hdl/pad_ctrl_top.sv
/* Pad-control top level: holds the mux and pad configuration banks and one
   routing cell per pad between the three peripheral groups and the pad frame. */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_ctrl_top (
  input  logic                                  ref_clk_i,
  input  logic                                  rst_n_i,

  // Configuration strobe, writes both fields of one pad
  input  logic                                  cfg_we_i,
  input  pad_ctrl_pkg::pad_idx_t                cfg_pad_i,
  input  pad_ctrl_pkg::padmux_sel_t             cfg_mux_i,
  input  pad_ctrl_pkg::padcfg_t                 cfg_padcfg_i,

  // PERIO group
  input  logic [`N_IO-1:0]                      perio_out_i,
  input  logic [`N_IO-1:0]                      perio_oe_i,
  output logic [`N_IO-1:0]                      perio_in_o,

  // APBIO group
  input  logic [`N_IO-1:0]                      apbio_out_i,
  input  logic [`N_IO-1:0]                      apbio_oe_i,
  output logic [`N_IO-1:0]                      apbio_in_o,

  // FPGAIO group
  input  logic [`N_IO-1:0]                      fpgaio_out_i,
  input  logic [`N_IO-1:0]                      fpgaio_oe_i,
  output logic [`N_IO-1:0]                      fpgaio_in_o,

  // Pad frame
  input  logic [`N_IO-1:0]                      io_in_i,
  output logic [`N_IO-1:0]                      io_out_o,
  output logic [`N_IO-1:0]                      io_oe_o,
  output pad_ctrl_pkg::padcfg_t [`N_IO-1:0]     pad_cfg_o
);

  import pad_ctrl_pkg::*;

  // Current owner of every pad
  padmux_sel_t [`N_IO-1:0] pad_mux_sel;

  // Mux selection bank
  pad_cfg_bank #(
    .entry_t   (padmux_sel_t),
    .RESET_VAL (PADMUX_OFF)
  ) i_mux_bank (
    .ref_clk_i (ref_clk_i),
    .rst_n_i   (rst_n_i),
    .we_i      (cfg_we_i),
    .idx_i     (cfg_pad_i),
    .data_i    (cfg_mux_i),
    .entries_o (pad_mux_sel)
  );

  // Electrical configuration bank, goes straight out to the pads
  pad_cfg_bank #(
    .entry_t   (padcfg_t),
    .RESET_VAL (PADCFG_RESET)
  ) i_padcfg_bank (
    .ref_clk_i (ref_clk_i),
    .rst_n_i   (rst_n_i),
    .we_i      (cfg_we_i),
    .idx_i     (cfg_pad_i),
    .data_i    (cfg_padcfg_i),
    .entries_o (pad_cfg_o)
  );

  // One cell per pad, group vectors sliced bit by bit
  for (genvar i = 0; i < `N_IO; i++) begin : g_pad
    pad_mux_cell i_pad_mux_cell (
      .ref_clk_i    (ref_clk_i),
      .rst_n_i      (rst_n_i),
      .sel_i        (pad_mux_sel[i]),

      .perio_out_i  (perio_out_i[i]),
      .perio_oe_i   (perio_oe_i[i]),
      .apbio_out_i  (apbio_out_i[i]),
      .apbio_oe_i   (apbio_oe_i[i]),
      .fpgaio_out_i (fpgaio_out_i[i]),
      .fpgaio_oe_i  (fpgaio_oe_i[i]),

      .pad_in_i     (io_in_i[i]),
      .pad_out_o    (io_out_o[i]),
      .pad_oe_o     (io_oe_o[i]),

      // Gathered back into the group input vectors
      .perio_in_o   (perio_in_o[i]),
      .apbio_in_o   (apbio_in_o[i]),
      .fpgaio_in_o  (fpgaio_in_o[i])
    );
  end

endmodule

//--- dv/pad_ctrl_asserts.sv
/* Concurrent checks on the pad-control top level, bound into every instance of it.
   Covers the enables in and out of reset and when pad configuration may change. */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_ctrl_asserts (
  input logic                                ref_clk_i,
  input logic                                rst_n_i,
  input logic                                cfg_we_i,
  input pad_ctrl_pkg::padmux_sel_t [`N_IO-1:0] pad_mux_sel,
  input logic [`N_IO-1:0]                    io_oe_o,
  input pad_ctrl_pkg::padcfg_t [`N_IO-1:0]   pad_cfg_o
);

  import pad_ctrl_pkg::*;

  logic [`N_IO-1:0] off_mask;

  // Pads released by the mux bank
  for (genvar i = 0; i < `N_IO; i++) begin : g_off
    assign off_mask[i] = (pad_mux_sel[i] == PADMUX_OFF);
  end

  a_oe_in_reset: assert property (@(posedge ref_clk_i) !rst_n_i |-> (io_oe_o == '0))
    else $error("io_oe_o is set while in reset");

  a_off_no_oe: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    (io_oe_o & off_mask) == '0)
    else $error("a released pad has its output enable set");

  // Configuration only moves on the edge that samples a strobe
  a_cfg_after_we: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    $changed(pad_cfg_o) |-> $past(cfg_we_i))
    else $error("pad_cfg_o changed without a configuration strobe");

endmodule

bind pad_ctrl_top pad_ctrl_asserts i_pad_ctrl_asserts (
  .ref_clk_i   (ref_clk_i),
  .rst_n_i     (rst_n_i),
  .cfg_we_i    (cfg_we_i),
  .pad_mux_sel (pad_mux_sel),
  .io_oe_o     (io_oe_o),
  .pad_cfg_o   (pad_cfg_o)
);

//--- dv/pad_ctrl_tb.sv
/* Self-checking testbench for the pad-control top level. Drives configuration strobes,
   group vectors and pad inputs, and compares the DUT against a reference model. */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_ctrl_tb;

  import pad_ctrl_pkg::*;

  localparam int RESET_TIMEOUT = 8;
  localparam int STEER_TIMEOUT = 8;

  logic                   ref_clk_i;
  logic                   rst_n_i;
  logic                   cfg_we_i;
  pad_idx_t               cfg_pad_i;
  padmux_sel_t            cfg_mux_i;
  padcfg_t                cfg_padcfg_i;
  logic [`N_IO-1:0]       perio_out_i;
  logic [`N_IO-1:0]       perio_oe_i;
  logic [`N_IO-1:0]       perio_in_o;
  logic [`N_IO-1:0]       apbio_out_i;
  logic [`N_IO-1:0]       apbio_oe_i;
  logic [`N_IO-1:0]       apbio_in_o;
  logic [`N_IO-1:0]       fpgaio_out_i;
  logic [`N_IO-1:0]       fpgaio_oe_i;
  logic [`N_IO-1:0]       fpgaio_in_o;
  logic [`N_IO-1:0]       io_in_i;
  logic [`N_IO-1:0]       io_out_o;
  logic [`N_IO-1:0]       io_oe_o;
  padcfg_t [`N_IO-1:0]    pad_cfg_o;

  // Reference model state
  padmux_sel_t [`N_IO-1:0] model_mux;
  padcfg_t     [`N_IO-1:0] model_cfg;
  logic        [`N_IO-1:0] sync_d1;
  logic        [`N_IO-1:0] sync_d2;

  logic [`N_IO-1:0] exp_out;
  logic [`N_IO-1:0] exp_oe;
  logic [`N_IO-1:0] exp_perio;
  logic [`N_IO-1:0] exp_apbio;
  logic [`N_IO-1:0] exp_fpgaio;

  int          check_errors;
  int          value_errors;
  int          timeout_errors;
  integer      seed;
  logic [31:0] rnd;
  bit          check_en;

  pad_ctrl_top DUT (
    .ref_clk_i    (ref_clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_pad_i    (cfg_pad_i),
    .cfg_mux_i    (cfg_mux_i),
    .cfg_padcfg_i (cfg_padcfg_i),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .perio_in_o   (perio_in_o),
    .apbio_out_i  (apbio_out_i),
    .apbio_oe_i   (apbio_oe_i),
    .apbio_in_o   (apbio_in_o),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .fpgaio_in_o  (fpgaio_in_o),
    .io_in_i      (io_in_i),
    .io_out_o     (io_out_o),
    .io_oe_o      (io_oe_o),
    .pad_cfg_o    (pad_cfg_o)
  );

  // 100 ns clock
  always #50 ref_clk_i = ~ref_clk_i;

  // Model registers follow every strobe the DUT samples
  always @(posedge ref_clk_i or negedge rst_n_i) begin : model_regs
    int i;
    if (!rst_n_i) begin
      for (i = 0; i < `N_IO; i++) begin
        model_mux[i] <= PADMUX_OFF;
        model_cfg[i] <= '0;
      end
    end else if (cfg_we_i) begin
      model_mux[cfg_pad_i] <= cfg_mux_i;
      model_cfg[cfg_pad_i] <= cfg_padcfg_i;
    end
  end

  // Pad input seen by the groups two edges later
  always @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_d1 <= '0;
      sync_d2 <= '0;
    end else begin
      sync_d1 <= io_in_i;
      sync_d2 <= sync_d1;
    end
  end

  // Pads owned by one group
  function automatic logic [`N_IO-1:0] group_mask(
    input padmux_sel_t [`N_IO-1:0] sel,
    input padmux_sel_t             grp
  );
    logic [`N_IO-1:0] mask;
    int p;
    mask = '0;
    for (p = 0; p < `N_IO; p++) begin
      mask[p] = (sel[p] == grp);
    end
    return mask;
  endfunction

  // Expected pad and group-side vectors for a selection set
  function automatic void reference_outputs(
    input  padmux_sel_t [`N_IO-1:0] sel,
    input  logic [`N_IO-1:0]        sync_in,
    output logic [`N_IO-1:0]        out_v,
    output logic [`N_IO-1:0]        oe_v,
    output logic [`N_IO-1:0]        perio_v,
    output logic [`N_IO-1:0]        apbio_v,
    output logic [`N_IO-1:0]        fpgaio_v
  );
    logic [`N_IO-1:0] m_p;
    logic [`N_IO-1:0] m_a;
    logic [`N_IO-1:0] m_f;
    m_p      = group_mask(sel, PADMUX_PERIO);
    m_a      = group_mask(sel, PADMUX_APBIO);
    m_f      = group_mask(sel, PADMUX_FPGAIO);
    // OFF pads fall out of all three masks
    out_v    = (perio_out_i & m_p) | (apbio_out_i & m_a) | (fpgaio_out_i & m_f);
    oe_v     = (perio_oe_i & m_p) | (apbio_oe_i & m_a) | (fpgaio_oe_i & m_f);
    perio_v  = sync_in & m_p;
    apbio_v  = sync_in & m_a;
    fpgaio_v = sync_in & m_f;
  endfunction

  task automatic check_vec(
    input logic [`N_IO-1:0] got,
    input logic [`N_IO-1:0] exp,
    input string            what,
    inout int               errs
  );
    if (got !== exp) begin
      errs++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(
    input padmux_sel_t      grp,
    input logic [`N_IO-1:0] got,
    input logic [`N_IO-1:0] exp,
    inout int               errs
  );
    if (got !== exp) begin
      errs++;
      $display("Fail at %0d ns: %s input vector is %h, expected %h",
               $time, grp.name(), got, exp);
    end
  endtask

  task automatic check_cfg(
    input padcfg_t [`N_IO-1:0] got,
    input padcfg_t [`N_IO-1:0] exp,
    input string               what,
    inout int                  errs
  );
    int p;
    for (p = 0; p < `N_IO; p++) begin
      if (got[p] !== exp[p]) begin
        errs++;
        $display("Fail at %0d ns: %s pad %0d is %h, expected %h", $time, what, p, got[p], exp[p]);
      end
    end
  endtask

  // Runs on every falling edge once reset is over
  always @(negedge ref_clk_i) begin
    if (check_en) begin
      reference_outputs(model_mux, sync_d2, exp_out, exp_oe, exp_perio, exp_apbio, exp_fpgaio);
      check_vec(io_out_o, exp_out, "io_out_o", check_errors);
      check_vec(io_oe_o, exp_oe, "io_oe_o", check_errors);
      check_mask(PADMUX_PERIO, perio_in_o, exp_perio, check_errors);
      check_mask(PADMUX_APBIO, apbio_in_o, exp_apbio, check_errors);
      check_mask(PADMUX_FPGAIO, fpgaio_in_o, exp_fpgaio, check_errors);
      check_cfg(pad_cfg_o, model_cfg, "pad_cfg_o", check_errors);
    end
  end

  task automatic idle_cycles(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(negedge ref_clk_i);
    end
  endtask

  task automatic write_pad(input int p, input padmux_sel_t sel, input padcfg_t cfg);
    @(negedge ref_clk_i);
    cfg_we_i     <= 1'b1;
    cfg_pad_i    <= pad_idx_t'(p);
    cfg_mux_i    <= sel;
    cfg_padcfg_i <= cfg;
  endtask

  task automatic end_write();
    @(negedge ref_clk_i);
    cfg_we_i <= 1'b0;
  endtask

  task automatic drive_groups();
    rnd = $random(seed);
    perio_out_i  <= rnd[`N_IO-1:0];
    perio_oe_i   <= rnd[31:32-`N_IO];
    rnd = $random(seed);
    apbio_out_i  <= rnd[`N_IO-1:0];
    apbio_oe_i   <= rnd[31:32-`N_IO];
    rnd = $random(seed);
    fpgaio_out_i <= rnd[`N_IO-1:0];
    fpgaio_oe_i  <= rnd[31:32-`N_IO];
  endtask

  task automatic wait_reset_release();
    int cnt;
    cnt = 0;
    while (!rst_n_i && cnt < RESET_TIMEOUT) begin
      @(negedge ref_clk_i);
      cnt++;
    end
    if (!rst_n_i) begin
      timeout_errors++;
      $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
    end
  endtask

  // Polls until each group sees its share of the given pad input
  task automatic wait_steered(input logic [`N_IO-1:0] pads, output int edges, output bit ok);
    edges = 0;
    ok    = 1'b0;
    while (!ok && edges < STEER_TIMEOUT) begin
      @(negedge ref_clk_i);
      edges++;
      ok = (perio_in_o == (pads & group_mask(model_mux, PADMUX_PERIO))) &&
           (apbio_in_o == (pads & group_mask(model_mux, PADMUX_APBIO))) &&
           (fpgaio_in_o == (pads & group_mask(model_mux, PADMUX_FPGAIO)));
    end
    if (!ok) begin
      timeout_errors++;
      $display("Timeout: group inputs did not follow io_in_i within %0d cycles", STEER_TIMEOUT);
    end
  endtask

  initial begin
    int               edges;
    bit               ok;
    int               p;
    int               iter;
    logic [`N_IO-1:0] pad_bit;
    logic [`N_IO-1:0] new_in;
    seed           = 4;
    check_errors   = 0;
    value_errors   = 0;
    timeout_errors = 0;
    check_en       = 1'b0;
    ref_clk_i      = 1'b0;
    rst_n_i        <= 1'b0;
    cfg_we_i       <= 1'b0;
    cfg_pad_i      <= '0;
    cfg_mux_i      <= PADMUX_OFF;
    cfg_padcfg_i   <= '0;
    perio_out_i    <= '0;
    perio_oe_i     <= '0;
    apbio_out_i    <= '0;
    apbio_oe_i     <= '0;
    fpgaio_out_i   <= '0;
    fpgaio_oe_i    <= '0;
    io_in_i        <= '0;

    idle_cycles(1);
    // All groups and pads drive ones in reset so only OFF keeps the pads quiet
    perio_out_i  <= '1;
    perio_oe_i   <= '1;
    apbio_out_i  <= '1;
    apbio_oe_i   <= '1;
    fpgaio_out_i <= '1;
    fpgaio_oe_i  <= '1;
    io_in_i      <= '1;
    idle_cycles(1);
    rst_n_i <= 1'b1;
    wait_reset_release();

    // Reset state
    check_vec(io_out_o, '0, "io_out_o after reset", value_errors);
    check_vec(io_oe_o, '0, "io_oe_o after reset", value_errors);
    check_mask(PADMUX_PERIO, perio_in_o, '0, value_errors);
    check_mask(PADMUX_APBIO, apbio_in_o, '0, value_errors);
    check_mask(PADMUX_FPGAIO, fpgaio_in_o, '0, value_errors);
    check_cfg(pad_cfg_o, '0, "pad_cfg_o after reset", value_errors);
    check_en <= 1'b1;

    // Output routing with back-to-back strobes over all pads
    for (iter = 0; iter < 12; iter++) begin
      for (p = 0; p < `N_IO; p++) begin
        rnd = $random(seed);
        write_pad(p, padmux_sel_t'(rnd[1:0]), rnd[`NBIT_PADCFG+1:2]);
        drive_groups();
      end
      end_write();
      drive_groups();
      idle_cycles(2);
    end

    // Pad configuration written one pad at a time
    for (p = 0; p < `N_IO; p++) begin
      rnd = $random(seed);
      write_pad(p, model_mux[p], rnd[`NBIT_PADCFG-1:0]);
      end_write();
      check_cfg(pad_cfg_o, model_cfg, "pad_cfg_o after single write", value_errors);
    end

    // Input steering with every group owning at least one pad
    write_pad(0, PADMUX_PERIO, model_cfg[0]);
    write_pad(1, PADMUX_APBIO, model_cfg[1]);
    write_pad(2, PADMUX_FPGAIO, model_cfg[2]);
    end_write();
    for (iter = 0; iter < 8; iter++) begin
      idle_cycles(1);
      rnd       = $random(seed);
      new_in    = rnd[`N_IO-1:0];
      new_in[0] = ~io_in_i[0];
      new_in[1] = ~io_in_i[1];
      new_in[2] = ~io_in_i[2];
      io_in_i <= new_in;
      wait_steered(new_in, edges, ok);
      if (ok && edges != 2) begin
        value_errors++;
        $display("Fail at %0d ns: pad input reached the groups after %0d cycles, expected 2",
                 $time, edges);
      end
    end

    // Turning a pad off
    rnd        = $random(seed);
    p          = int'(rnd[3:0]);
    pad_bit    = '0;
    pad_bit[p] = 1'b1;
    write_pad(p, PADMUX_PERIO, model_cfg[p]);
    perio_out_i <= '1;
    perio_oe_i  <= '1;
    io_in_i     <= '1;
    end_write();
    wait_steered('1, edges, ok);
    check_vec(io_oe_o & pad_bit, pad_bit, "io_oe_o of selected pad", value_errors);
    write_pad(p, PADMUX_OFF, model_cfg[p]);
    end_write();
    check_vec(io_out_o & pad_bit, '0, "io_out_o of released pad", value_errors);
    check_vec(io_oe_o & pad_bit, '0, "io_oe_o of released pad", value_errors);
    check_mask(PADMUX_PERIO, perio_in_o & pad_bit, '0, value_errors);
    check_mask(PADMUX_APBIO, apbio_in_o & pad_bit, '0, value_errors);
    check_mask(PADMUX_FPGAIO, fpgaio_in_o & pad_bit, '0, value_errors);

    idle_cycles(2);
    $display("Errors: %0d from checker, %0d from directed checks, %0d timeouts",
             check_errors, value_errors, timeout_errors);
    if (check_errors == 0 && value_errors == 0 && timeout_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+hdl
hdl/pad_ctrl_pkg.sv
hdl/pad_cfg_bank.sv
hdl/pad_mux_cell.sv
hdl/pad_ctrl_top.sv
dv/pad_ctrl_asserts.sv
dv/pad_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the pad-control testbench

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/pad_ctrl_sim

.PHONY: all compile run clean

all: run

# Build the simulation model from the file list
compile:
	verilator --cc --main --timing --assert --build \
		-f files.f \
		--top-module pad_ctrl_tb \
		-Mdir $(OBJ_DIR) \
		-o pad_ctrl_sim

# Run the model and search its output for the pass message
run: compile
	@out="$$(./$(SIM))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
